/* list.f */
+incdir+src
src/bp_pkg.sv
src/pattern_table.sv
src/predict_slot.sv
src/history_reg.sv
src/gshare_predictor.sv
tests/gshare_props.sv
tests/gshare_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the gshare testbench with Verilator, then scan the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module gshare_tb -f list.f > sim.log 2>&1 &&
    ./obj_dir/Vgshare_tb >> sim.log 2>&1 ||
    echo "** FAIL **" >> sim.log

cat sim.log
grep -qF "** FAIL **" sim.log && exit 1 || exit 0

/* src/bp_macros.svh */
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// ----------------------------------------
// Pattern table geometry
// ----------------------------------------
`define BP_ENTRIES    32
`define BP_INDEX_W    5

// Fetch address width
`define BP_ADDR_W     32

// History bits mixed into the hash, 1 up to BP_INDEX_W
`define BP_GH_LEN     2

// ----------------------------------------
// Fetch group and resolve widths
// ----------------------------------------
`define BP_SLOTS      5
`define BP_UPD_PORTS  3

`endif

/* src/bp_pkg.sv */
`include "bp_macros.svh"

package bp_pkg;

    // Two-bit saturating counter, upper bit is the prediction
    typedef logic [1:0] ctr_t;

    // Global history, newest outcome in bit 0
    typedef logic [`BP_INDEX_W-1:0] ghr_t;

    typedef logic [`BP_INDEX_W-1:0] index_t;

    // Record handed back with each fetch slot for later resolve
    typedef struct packed {
        ghr_t hist;
        logic pred;
    } hist_rec_t;

    typedef struct packed {
        logic [`BP_ADDR_W-1:0] pc;
        logic                  is_branch;
        logic                  ignore;
    } fetch_slot_t;

    typedef struct packed {
        logic                  valid;
        logic [`BP_ADDR_W-1:0] pc;
        logic                  mispredict;
        hist_rec_t             rec;
    } resolve_t;

    // Word bits of the PC folded with the next field, then mixed with history
    function automatic index_t gshare_index(input logic [`BP_ADDR_W-1:0] pc, input ghr_t hist);
        index_t pc_fold;
        index_t gh_mask;
        pc_fold = pc[`BP_INDEX_W+1:2] ^ pc[2*`BP_INDEX_W+1:`BP_INDEX_W+2];
        gh_mask = '0;
        gh_mask[`BP_GH_LEN-1:0] = hist[`BP_GH_LEN-1:0];
        return pc_fold ^ gh_mask;
    endfunction

    // Actual direction recovered from the predicted bit
    function automatic logic actual_taken(input resolve_t res);
        return res.rec.pred ^ res.mispredict;
    endfunction

endpackage

/* src/gshare_predictor.sv */
`timescale 1ns/1ps
`include "bp_macros.svh"

module gshare_predictor
    import bp_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 fetch_valid_i,
    input  fetch_slot_t [`BP_SLOTS-1:0]          fetch_i,
    input  resolve_t    [`BP_UPD_PORTS-1:0]      resolve_i,
    output logic        [`BP_SLOTS-1:0]          taken_o,
    output hist_rec_t   [`BP_SLOTS-1:0]          hist_rec_o
);

    ghr_t ghr;

    // Entry k is the history seen by slot k, the last entry follows slot 4
    ghr_t   [`BP_SLOTS:0]   hist_next;
    logic   [`BP_SLOTS-1:0] slot_taken;
    index_t [`BP_SLOTS-1:0] rd_index;
    logic   [`BP_SLOTS-1:0] rd_taken;

    assign hist_next[0] = ghr;

    // ----------------------------------------
    // Counter storage and training
    // ----------------------------------------
    pattern_table u_table (
        .clk        (clk),
        .reset      (reset),
        .rd_index_i (rd_index),
        .rd_taken_o (rd_taken),
        .resolve_i  (resolve_i)
    );

    // ----------------------------------------
    // Fetch slot chain
    // ----------------------------------------
    for (genvar k = 0; k < `BP_SLOTS; k++) begin : g_slot
        predict_slot u_slot (
            .slot_i       (fetch_i[k]),
            .hist_i       (hist_next[k]),
            .index_o      (rd_index[k]),
            .ctr_taken_i  (rd_taken[k]),
            .taken_o      (taken_o[k]),
            .slot_taken_o (slot_taken[k]),
            .hist_o       (hist_next[k+1]),
            .rec_o        (hist_rec_o[k])
        );
    end

    // ----------------------------------------
    // Global history
    // ----------------------------------------
    history_reg u_ghr (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid_i (fetch_valid_i),
        .resolve_i     (resolve_i),
        .hist_after_i  (hist_next[`BP_SLOTS:1]),
        .slot_taken_i  (slot_taken),
        .ghr_o         (ghr)
    );

endmodule

/* src/history_reg.sv */
`timescale 1ns/1ps
`include "bp_macros.svh"

module history_reg
    import bp_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             fetch_valid_i,
    input  resolve_t [`BP_UPD_PORTS-1:0]     resolve_i,
    input  ghr_t     [`BP_SLOTS-1:0]         hist_after_i,
    input  logic     [`BP_SLOTS-1:0]         slot_taken_i,
    output ghr_t                             ghr_o
);

    ghr_t ghr_q;
    ghr_t fetch_next;
    ghr_t restore_hist;
    logic restore;

    // ----------------------------------------
    // Mispredict restore
    // ----------------------------------------
    // Walk from the highest port down so the lowest mispredict wins
    always_comb begin
        restore      = 1'b0;
        restore_hist = resolve_i[0].rec.hist;
        for (int p = `BP_UPD_PORTS - 1; p >= 0; p--) begin
            if (resolve_i[p].mispredict) begin
                restore = 1'b1;
                if (resolve_i[p].valid) begin
                    // Branch redirect appends the real outcome
                    restore_hist = {resolve_i[p].rec.hist[`BP_INDEX_W-2:0],
                                    actual_taken(resolve_i[p])};
                end else begin
                    // Indirect jump redirect, history back as saved
                    restore_hist = resolve_i[p].rec.hist;
                end
            end
        end
    end

    // ----------------------------------------
    // Speculative fetch advance
    // ----------------------------------------
    // Stop at the first predicted-taken slot, else take the whole group
    always_comb begin
        fetch_next = hist_after_i[`BP_SLOTS-1];
        for (int s = `BP_SLOTS - 1; s >= 0; s--) begin
            if (slot_taken_i[s]) begin
                fetch_next = hist_after_i[s];
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ghr_q <= '0;
        end else if (restore) begin
            ghr_q <= restore_hist;
        end else if (fetch_valid_i) begin
            ghr_q <= fetch_next;
        end
    end

    assign ghr_o = ghr_q;

endmodule

/* src/pattern_table.sv */
`timescale 1ns/1ps
`include "bp_macros.svh"

module pattern_table
    import bp_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  index_t   [`BP_SLOTS-1:0]         rd_index_i,
    output logic     [`BP_SLOTS-1:0]         rd_taken_o,
    input  resolve_t [`BP_UPD_PORTS-1:0]     resolve_i
);

    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    ctr_t table_q [`BP_ENTRIES];

    index_t [`BP_UPD_PORTS-1:0] upd_index;
    logic   [`BP_UPD_PORTS-1:0] upd_taken;
    // Port owns the write for its index
    logic   [`BP_UPD_PORTS-1:0] upd_lead;
    ctr_t   [`BP_UPD_PORTS-1:0] upd_ctr;

    function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
        ctr_t next;
        next = ctr;
        if (taken) begin
            if (ctr != CTR_STRONG_T) begin
                next = ctr + 2'b01;
            end
        end else begin
            if (ctr != CTR_STRONG_NT) begin
                next = ctr - 2'b01;
            end
        end
        return next;
    endfunction

    // ----------------------------------------
    // Lookup
    // ----------------------------------------
    always_comb begin
        for (int s = 0; s < `BP_SLOTS; s++) begin
            rd_taken_o[s] = table_q[rd_index_i[s]][1];
        end
    end

    // ----------------------------------------
    // Training with same-index combining
    // ----------------------------------------
    always_comb begin
        for (int p = 0; p < `BP_UPD_PORTS; p++) begin
            upd_index[p] = gshare_index(resolve_i[p].pc, resolve_i[p].rec.hist);
            upd_taken[p] = actual_taken(resolve_i[p]);
        end

        for (int p = 0; p < `BP_UPD_PORTS; p++) begin
            // Skip ports already folded into an older valid port
            upd_lead[p] = resolve_i[p].valid;
            for (int q = 0; q < p; q++) begin
                if (resolve_i[q].valid && (upd_index[q] == upd_index[p])) begin
                    upd_lead[p] = 1'b0;
                end
            end

            // Apply this port, then younger ports on the same entry in order
            upd_ctr[p] = ctr_step(table_q[upd_index[p]], upd_taken[p]);
            for (int q = p + 1; q < `BP_UPD_PORTS; q++) begin
                if (resolve_i[q].valid && (upd_index[q] == upd_index[p])) begin
                    upd_ctr[p] = ctr_step(upd_ctr[p], upd_taken[q]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int e = 0; e < `BP_ENTRIES; e++) begin
                table_q[e] <= CTR_WEAK_NT;
            end
        end else begin
            for (int p = 0; p < `BP_UPD_PORTS; p++) begin
                if (upd_lead[p]) begin
                    table_q[upd_index[p]] <= upd_ctr[p];
                end
            end
        end
    end

endmodule

/* src/predict_slot.sv */
`timescale 1ns/1ps
`include "bp_macros.svh"

module predict_slot
    import bp_pkg::*;
(
    input  fetch_slot_t slot_i,
    input  ghr_t        hist_i,
    output index_t      index_o,
    input  logic        ctr_taken_i,
    output logic        taken_o,
    output logic        slot_taken_o,
    output ghr_t        hist_o,
    output hist_rec_t   rec_o
);

    logic is_branch;

    // Qualified conditional branch
    assign is_branch = slot_i.is_branch & ~slot_i.ignore;

    // Lookup uses history as advanced by the older slots
    assign index_o = gshare_index(slot_i.pc, hist_i);

    assign taken_o = is_branch & ctr_taken_i;

    // Redirect candidate for the history register
    assign slot_taken_o = is_branch & ctr_taken_i;

    // Only a qualified branch shifts its prediction in
    assign hist_o = is_branch ? {hist_i[`BP_INDEX_W-2:0], taken_o} : hist_i;

    // History before this slot plus its prediction
    assign rec_o.hist = hist_i;
    assign rec_o.pred = taken_o;

endmodule

/* tests/gshare_props.sv */
`timescale 1ns/1ps
`include "bp_macros.svh"

module gshare_props
    import bp_pkg::*;
(
    input logic                             clk,
    input logic                             reset,
    input logic                             fetch_valid_i,
    input fetch_slot_t [`BP_SLOTS-1:0]      fetch_i,
    input resolve_t    [`BP_UPD_PORTS-1:0]  resolve_i,
    input logic        [`BP_SLOTS-1:0]      taken_o,
    input hist_rec_t   [`BP_SLOTS-1:0]      hist_rec_o
);

    logic [`BP_SLOTS-1:0] qualified;
    logic                 any_mispredict;

    always_comb begin
        for (int s = 0; s < `BP_SLOTS; s++) begin
            qualified[s] = fetch_i[s].is_branch & ~fetch_i[s].ignore;
        end
        any_mispredict = 1'b0;
        for (int p = 0; p < `BP_UPD_PORTS; p++) begin
            any_mispredict = any_mispredict | resolve_i[p].mispredict;
        end
    end

    for (genvar k = 0; k < `BP_SLOTS; k++) begin : g_slot_props
        assert property (@(posedge clk) disable iff (!reset) taken_o[k] |-> qualified[k])
            else $error("taken_o[%0d] set on a slot that is not a qualified branch", k);

        // History passes through a slot that is not a qualified branch
        if (k < `BP_SLOTS - 1) begin : g_pass
            assert property (@(posedge clk) disable iff (!reset)
                !qualified[k] |-> hist_rec_o[k+1].hist == hist_rec_o[k].hist)
                else $error("Slot %0d changed the history without a branch", k);
        end
    end

    assert property (@(posedge clk) disable iff (!reset)
        (!fetch_valid_i && !any_mispredict) |=> $stable(hist_rec_o[0].hist))
        else $error("Global history moved without a fetch group or a mispredict");

endmodule

bind gshare_predictor gshare_props u_props (
    .clk           (clk),
    .reset         (reset),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .resolve_i     (resolve_i),
    .taken_o       (taken_o),
    .hist_rec_o    (hist_rec_o)
);

/* tests/gshare_tb.sv */
`timescale 1ns/1ps
`include "bp_macros.svh"

module gshare_tb
    import bp_pkg::*;
;

    localparam int N_RANDOM   = 3000;
    localparam int MAX_CYCLES = 5000;

    // Small PC pool where PC_B maps to the same index as PC_A
    localparam logic [`BP_ADDR_W-1:0] PC_A = 32'h0000_1040;
    localparam logic [`BP_ADDR_W-1:0] PC_B = 32'h0000_1FBC;
    localparam logic [`BP_ADDR_W-1:0] PC_C = 32'h0000_2188;
    localparam logic [`BP_ADDR_W-1:0] PC_D = 32'h0000_30E4;

    typedef hist_rec_t [`BP_SLOTS-1:0] rec_vec_t;

    logic                                clk;
    logic                                reset;
    logic                                fetch_valid;
    fetch_slot_t [`BP_SLOTS-1:0]         fetch;
    resolve_t    [`BP_UPD_PORTS-1:0]     resolve;
    logic        [`BP_SLOTS-1:0]         taken;
    hist_rec_t   [`BP_SLOTS-1:0]         hist_rec;

    integer      seed;
    int          check_count;
    int          error_count;

    // Reference state
    ctr_t        ref_tbl [`BP_ENTRIES];
    ghr_t        ref_ghr;
    rec_vec_t    exp_rec;
    ghr_t        exp_ghr;

    gshare_predictor u_gshare_predictor (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid_i (fetch_valid),
        .fetch_i       (fetch),
        .resolve_i     (resolve),
        .taken_o       (taken),
        .hist_rec_o    (hist_rec)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic index_t ref_index(input logic [`BP_ADDR_W-1:0] pc, input ghr_t hist);
        index_t idx;
        for (int b = 0; b < `BP_INDEX_W; b++) begin
            idx[b] = pc[2 + b] ^ pc[2 + `BP_INDEX_W + b];
            if (b < `BP_GH_LEN) begin
                idx[b] = idx[b] ^ hist[b];
            end
        end
        return idx;
    endfunction

    // Records for every slot with history advanced by older qualified branches
    function automatic rec_vec_t model_predict(input fetch_slot_t [`BP_SLOTS-1:0] f,
                                               input ghr_t g);
        rec_vec_t recs;
        ghr_t     h;
        logic     br;
        logic     p;
        h = g;
        for (int s = 0; s < `BP_SLOTS; s++) begin
            br = f[s].is_branch && !f[s].ignore;
            p  = br ? ref_tbl[ref_index(f[s].pc, h)][1] : 1'b0;
            recs[s].hist = h;
            recs[s].pred = p;
            if (br) begin
                h = {h[`BP_INDEX_W-2:0], p};
            end
        end
        return recs;
    endfunction

    function automatic ghr_t model_next_ghr(input logic v,
                                            input fetch_slot_t [`BP_SLOTS-1:0] f,
                                            input resolve_t [`BP_UPD_PORTS-1:0] res,
                                            input ghr_t g, input rec_vec_t recs);
        ghr_t nxt;
        logic restore;
        logic stop;
        nxt     = g;
        restore = 1'b0;
        stop    = 1'b0;
        for (int p = 0; p < `BP_UPD_PORTS; p++) begin
            if (!restore && res[p].mispredict) begin
                restore = 1'b1;
                // A mispredicted branch went the other way
                nxt = res[p].valid ? {res[p].rec.hist[`BP_INDEX_W-2:0], ~res[p].rec.pred}
                                   : res[p].rec.hist;
            end
        end
        if (!restore && v) begin
            for (int s = 0; s < `BP_SLOTS; s++) begin
                if (!stop && f[s].is_branch && !f[s].ignore) begin
                    nxt  = {recs[s].hist[`BP_INDEX_W-2:0], recs[s].pred};
                    stop = recs[s].pred;
                end
            end
        end
        return nxt;
    endfunction

    // Port order applied one after another on the same array
    task automatic model_train(input resolve_t [`BP_UPD_PORTS-1:0] res);
        index_t idx;
        logic   act;
        for (int p = 0; p < `BP_UPD_PORTS; p++) begin
            if (res[p].valid) begin
                idx = ref_index(res[p].pc, res[p].rec.hist);
                act = res[p].rec.pred ^ res[p].mispredict;
                if (act && ref_tbl[idx] != 2'b11) begin
                    ref_tbl[idx] = ref_tbl[idx] + 2'b01;
                end else if (!act && ref_tbl[idx] != 2'b00) begin
                    ref_tbl[idx] = ref_tbl[idx] - 2'b01;
                end
            end
        end
    endtask

    task automatic check_value(input string name, input int slot,
                               input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s[%0d]: got 0x%h, expected 0x%h", name, slot, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Compare after the falling-edge drive, then advance the model
    always @(negedge clk) begin
        #2;
        if (!reset) begin
            for (int e = 0; e < `BP_ENTRIES; e++) begin
                ref_tbl[e] = 2'b01;
            end
            ref_ghr = '0;
        end else begin
            exp_rec = model_predict(fetch, ref_ghr);
            for (int s = 0; s < `BP_SLOTS; s++) begin
                check_value("taken_o", s, 32'(taken[s]), 32'(exp_rec[s].pred));
                check_value("hist_rec_o", s, 32'(hist_rec[s]), 32'(exp_rec[s]));
            end
            exp_ghr = model_next_ghr(fetch_valid, fetch, resolve, ref_ghr, exp_rec);
            model_train(resolve);
            ref_ghr = exp_ghr;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic logic [`BP_ADDR_W-1:0] pool_pc(input logic [1:0] sel);
        case (sel)
            2'd0:    return PC_A;
            2'd1:    return PC_B;
            2'd2:    return PC_C;
            default: return PC_D;
        endcase
    endfunction

    task automatic clear_inputs();
        fetch_valid = 1'b0;
        fetch       = '0;
        resolve     = '0;
    endtask

    task automatic set_slot(input int s, input logic [`BP_ADDR_W-1:0] pc,
                            input logic br, input logic ign);
        fetch[s].pc        = pc;
        fetch[s].is_branch = br;
        fetch[s].ignore    = ign;
    endtask

    task automatic set_resolve(input int p, input logic v, input logic [`BP_ADDR_W-1:0] pc,
                               input ghr_t hist, input logic pred, input logic misp);
        resolve[p].valid      = v;
        resolve[p].pc         = pc;
        resolve[p].rec.hist   = hist;
        resolve[p].rec.pred   = pred;
        resolve[p].mispredict = misp;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = $random(seed);
        fetch_valid = (r[1:0] != 2'b00);
        for (int s = 0; s < `BP_SLOTS; s++) begin
            r = $random(seed);
            set_slot(s, pool_pc(r[1:0]), r[2] | r[3], r[6:4] == 3'b000);
        end
        for (int p = 0; p < `BP_UPD_PORTS; p++) begin
            r = $random(seed);
            set_resolve(p, r[3] | r[4], pool_pc(r[6:5]), r[11:7], r[12], r[2:0] == 3'b000);
        end
    endtask

    // Cycle-count watchdog
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        seed        = 32'hb653_bebf;
        check_count = 0;
        error_count = 0;
        reset       = 1'b0;
        clear_inputs();
        repeat (10) @(negedge clk);
        reset = 1'b1;

        // Fresh table with every slot a branch
        for (int s = 0; s < `BP_SLOTS; s++) begin
            set_slot(s, pool_pc(2'(s)), 1'b1, 1'b0);
        end

        // Train to strong taken, then down to strong not-taken
        repeat (3) begin
            @(negedge clk);
            clear_inputs();
            set_slot(0, PC_A, 1'b1, 1'b0);
            set_resolve(0, 1'b1, PC_A, '0, 1'b1, 1'b0);
            set_resolve(1, 1'b1, PC_B, '0, 1'b1, 1'b0);
        end
        repeat (3) begin
            @(negedge clk);
            for (int p = 0; p < `BP_UPD_PORTS; p++) begin
                set_resolve(p, 1'b1, PC_A, '0, 1'b0, 1'b0);
            end
        end

        // Three ports on one strong not-taken index step to weak taken only in port order
        @(negedge clk);
        set_resolve(0, 1'b1, PC_A, '0, 1'b0, 1'b0);
        set_resolve(1, 1'b1, PC_B, '0, 1'b1, 1'b0);
        set_resolve(2, 1'b1, PC_A, '0, 1'b0, 1'b1);
        @(negedge clk);
        clear_inputs();
        set_slot(0, PC_A, 1'b1, 1'b0);
        set_resolve(0, 1'b1, PC_A, '0, 1'b1, 1'b0);

        // Valid group with non-branch, ignored and taken slots
        @(negedge clk);
        clear_inputs();
        fetch_valid = 1'b1;
        set_slot(0, PC_A, 1'b0, 1'b0);
        set_slot(1, PC_D, 1'b1, 1'b1);
        set_slot(2, PC_C, 1'b1, 1'b0);
        set_slot(3, PC_A, 1'b1, 1'b0);
        set_slot(4, PC_D, 1'b1, 1'b0);

        // Two restores in one cycle that each beat the fetch advance
        @(negedge clk);
        set_resolve(0, 1'b1, PC_C, 5'h04, 1'b0, 1'b0);
        set_resolve(1, 1'b1, PC_C, 5'h0A, 1'b1, 1'b1);
        set_resolve(2, 1'b0, PC_D, 5'h1F, 1'b0, 1'b1);
        @(negedge clk);
        set_resolve(0, 1'b0, PC_B, 5'h13, 1'b0, 1'b1);
        set_resolve(1, 1'b0, PC_B, 5'h00, 1'b0, 1'b0);
        set_resolve(2, 1'b1, PC_D, 5'h07, 1'b1, 1'b1);

        for (int cyc = 0; cyc < N_RANDOM; cyc++) begin
            @(negedge clk);
            drive_random();
        end

        @(negedge clk);
        clear_inputs();
        #3;
        if (error_count == 0 && check_count > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("No output checks were run");
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule
